//--- src/bnn_spi_pkg.sv
package bnn_spi_pkg;

  // ========================================================================
  // Widths that carry a meaning
  // ========================================================================
  // SPI bytes, buffer data and weights
  typedef logic [7:0] byte_t;
  // Buffer address 0 to 112
  typedef logic [6:0] img_addr_t;
  // Class score 0 to 900
  typedef logic [9:0] score_t;
  // Class index 0 to 9
  typedef logic [3:0] class_t;
  // Inter-byte timeout counter
  typedef logic [9:0] tmo_cnt_t;

  // ========================================================================
  // Image geometry and protocol constants
  // ========================================================================
  localparam int IMG_BITS       = 900;
  localparam int IMG_BYTES      = 113;
  // Valid low bits of the final byte
  localparam int LAST_BYTE_BITS = 4;
  localparam int NUM_CLASSES    = 10;

  localparam byte_t     LAST_BYTE_MASK = byte_t'((1 << LAST_BYTE_BITS) - 1);
  localparam img_addr_t LAST_ADDR      = img_addr_t'(IMG_BYTES - 1);
  localparam img_addr_t FULL_PTR       = img_addr_t'(IMG_BYTES);

  // Command codes
  localparam byte_t STATUS_REQUEST_CODE = 8'hFE;
  localparam byte_t IMG_TX_REQUEST_CODE = 8'hBF;

  // Idle cycles allowed between bytes of a transfer
  localparam int       TIMEOUT_CYCLES = 1024;
  localparam tmo_cnt_t TMO_LAST       = tmo_cnt_t'(TIMEOUT_CYCLES - 1);

  // Controller states
  typedef enum logic [2:0] {
    S_IDLE           = 3'd0,
    S_RX_CMD         = 3'd1,
    S_CMD_LATCH      = 3'd2,
    S_IMG_RX         = 3'd3,
    S_CMD_DISPATCH   = 3'd4,
    S_STATUS_READY   = 3'd5,
    S_WAIT_INFERENCE = 3'd6,
    S_CLEAR          = 3'd7
  } ctrl_state_t;

  // Fixed weight rule, low byte of a*(2c+3) + 29c
  // Only the low 8 bits matter so the math stays 8 bits wide
  function automatic byte_t weight_byte(input class_t c, input img_addr_t a);
    byte_t addr_v;
    byte_t mult_v;
    byte_t offs_v;
    addr_v = byte_t'(a);
    mult_v = byte_t'(c) * 8'd2 + 8'd3;
    offs_v = byte_t'(c) * 8'd29;
    return byte_t'(addr_v * mult_v + offs_v);
  endfunction

endpackage

//--- src/spi_byte_rx.sv
`timescale 1ns/1ps

module spi_byte_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               spi_sclk,
  input  logic               spi_mosi,
  input  logic               spi_cs_n,
  input  logic               byte_taken,
  output bnn_spi_pkg::byte_t rx_data,
  output logic               byte_valid,
  output logic               cs_n_sync
);

  // Pin order in the sync vectors is {cs_n, mosi, sclk}
  logic [2:0] pin_s1;
  logic [2:0] pin_s2;
  logic       sclk_prev;
  logic       sclk_rise;
  logic       mosi_sync;
  logic [2:0] bit_cnt;
  bnn_spi_pkg::byte_t shift_reg;

  // ========================================================================
  // Two-flop synchronizers for all three pins
  // ========================================================================
  // Chip select idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pin_s1 <= 3'b100;
      pin_s2 <= 3'b100;
    end else begin
      pin_s1 <= {spi_cs_n, spi_mosi, spi_sclk};
      pin_s2 <= pin_s1;
    end
  end

  assign cs_n_sync = pin_s2[2];
  assign mosi_sync = pin_s2[1];
  assign sclk_rise = pin_s2[0] & ~sclk_prev;

  // ========================================================================
  // Mode 0 deserializer, MSB first
  // ========================================================================
  // Data shifts on every synced sclk rise inside the frame
  always_ff @(posedge clk) begin
    if (!cs_n_sync && sclk_rise) begin
      shift_reg <= {shift_reg[6:0], mosi_sync};
    end
  end

  // Shift register only moves again on the rise that drops byte_valid
  assign rx_data = shift_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_prev  <= 1'b0;
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      sclk_prev <= pin_s2[0];
      if (cs_n_sync) begin
        // Frame closed, drop partial byte
        bit_cnt    <= 3'd0;
        byte_valid <= 1'b0;
      end else if (sclk_rise) begin
        bit_cnt    <= bit_cnt + 3'd1;
        // High after eighth bit, low again on the next bit
        byte_valid <= (bit_cnt == 3'd7);
      end else if (byte_taken) begin
        byte_valid <= 1'b0;
      end
    end
  end

endmodule

//--- src/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cs_n_sync,
  input  bnn_spi_pkg::byte_t       rx_data,
  input  logic                     byte_valid,
  input  logic                     buffer_full,
  input  logic                     buffer_empty,
  input  logic                     result_ready,
  output logic                     byte_taken,
  output logic                     buffer_write_enable,
  output logic                     clear_buffer,
  output logic                     bnn_start,
  output logic                     status_ready,
  output logic                     send_image,
  output bnn_spi_pkg::ctrl_state_t fsm_state
);

  bnn_spi_pkg::ctrl_state_t ctrl_state;
  bnn_spi_pkg::ctrl_state_t next_state;
  bnn_spi_pkg::byte_t       command_byte;
  bnn_spi_pkg::tmo_cnt_t    timeout_cnt;
  logic cs_prev;
  logic byte_valid_prev;
  logic cs_falling;
  logic cs_rising;
  logic byte_rise;
  logic timeout;
  logic rx_active;
  logic status_req;
  logic img_req;

  // ========================================================================
  // Edge detection on chip select and byte_valid
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cs_prev         <= 1'b1;
      byte_valid_prev <= 1'b0;
    end else begin
      cs_prev         <= cs_n_sync;
      byte_valid_prev <= byte_valid;
    end
  end

  assign cs_falling = ~cs_n_sync & cs_prev;
  assign cs_rising  = cs_n_sync & ~cs_prev;
  assign byte_rise  = byte_valid & ~byte_valid_prev;
  assign rx_active  = (ctrl_state == bnn_spi_pkg::S_RX_CMD) ||
                      (ctrl_state == bnn_spi_pkg::S_IMG_RX);

  // ========================================================================
  // Command latch and decode
  // ========================================================================
  // Captured on the first byte of the frame
  always_ff @(posedge clk) begin
    if (ctrl_state == bnn_spi_pkg::S_RX_CMD && byte_rise) begin
      command_byte <= rx_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_req <= 1'b0;
      img_req    <= 1'b0;
    end else if (ctrl_state == bnn_spi_pkg::S_CMD_LATCH) begin
      status_req <= (command_byte == bnn_spi_pkg::STATUS_REQUEST_CODE);
      img_req    <= (command_byte == bnn_spi_pkg::IMG_TX_REQUEST_CODE);
    end else if (ctrl_state == bnn_spi_pkg::S_IDLE) begin
      status_req <= 1'b0;
      img_req    <= 1'b0;
    end
  end

  // ========================================================================
  // Inter-byte timeout
  // ========================================================================
  // Restarts on every new byte while receiving
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timeout_cnt <= '0;
    end else if (rx_active && !byte_rise) begin
      timeout_cnt <= timeout_cnt + 1'b1;
    end else begin
      timeout_cnt <= '0;
    end
  end

  assign timeout = (timeout_cnt == bnn_spi_pkg::TMO_LAST);

  // ========================================================================
  // State register and next state
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_state <= bnn_spi_pkg::S_IDLE;
    end else begin
      ctrl_state <= next_state;
    end
  end

  always_comb begin
    next_state = ctrl_state;
    case (ctrl_state)
      bnn_spi_pkg::S_IDLE: begin
        if (cs_falling) next_state = bnn_spi_pkg::S_RX_CMD;
      end
      bnn_spi_pkg::S_RX_CMD: begin
        if (timeout) next_state = bnn_spi_pkg::S_IDLE;
        else if (byte_rise) next_state = bnn_spi_pkg::S_CMD_LATCH;
      end
      bnn_spi_pkg::S_CMD_LATCH: next_state = bnn_spi_pkg::S_CMD_DISPATCH;
      bnn_spi_pkg::S_CMD_DISPATCH: begin
        // Unknown codes fall back to idle
        if (img_req) next_state = bnn_spi_pkg::S_IMG_RX;
        else if (status_req) next_state = bnn_spi_pkg::S_STATUS_READY;
        else next_state = bnn_spi_pkg::S_IDLE;
      end
      bnn_spi_pkg::S_STATUS_READY: next_state = bnn_spi_pkg::S_IDLE;
      bnn_spi_pkg::S_IMG_RX: begin
        // Full image wins over a late abort
        if (buffer_full) next_state = bnn_spi_pkg::S_WAIT_INFERENCE;
        else if (cs_rising || timeout) next_state = bnn_spi_pkg::S_CLEAR;
      end
      bnn_spi_pkg::S_WAIT_INFERENCE: begin
        if (result_ready) next_state = bnn_spi_pkg::S_CLEAR;
      end
      bnn_spi_pkg::S_CLEAR: begin
        if (buffer_empty) next_state = bnn_spi_pkg::S_IDLE;
      end
      default: next_state = bnn_spi_pkg::S_IDLE;
    endcase
  end

  // ========================================================================
  // Strobes and levels to the datapath
  // ========================================================================
  always_comb begin
    byte_taken          = 1'b0;
    buffer_write_enable = 1'b0;
    clear_buffer        = 1'b0;
    bnn_start           = 1'b0;
    case (ctrl_state)
      bnn_spi_pkg::S_RX_CMD: byte_taken = byte_rise;
      bnn_spi_pkg::S_IMG_RX: begin
        byte_taken          = byte_rise;
        // Late bytes past a full buffer are dropped
        buffer_write_enable = byte_rise & ~buffer_full;
      end
      bnn_spi_pkg::S_WAIT_INFERENCE: bnn_start = 1'b1;
      bnn_spi_pkg::S_CLEAR: clear_buffer = 1'b1;
      default: ;
    endcase
  end

  // Status flag lives until the next frame opens
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_ready <= 1'b0;
    end else if (ctrl_state == bnn_spi_pkg::S_CMD_DISPATCH && !img_req && status_req) begin
      status_ready <= 1'b1;
    end else if (cs_falling) begin
      status_ready <= 1'b0;
    end
  end

  // Image transfer flag, dropped on return to idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      send_image <= 1'b0;
    end else if (ctrl_state == bnn_spi_pkg::S_CMD_DISPATCH && img_req) begin
      send_image <= 1'b1;
    end else if (next_state == bnn_spi_pkg::S_IDLE) begin
      send_image <= 1'b0;
    end
  end

  assign fsm_state = ctrl_state;

endmodule

//--- src/image_buffer.sv
`timescale 1ns/1ps

module image_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   buffer_write_enable,
  input  bnn_spi_pkg::byte_t     wr_data,
  input  logic                   clear_buffer,
  input  bnn_spi_pkg::img_addr_t rd_addr,
  output bnn_spi_pkg::byte_t     rd_data,
  output logic                   buffer_full,
  output logic                   buffer_empty
);

  bnn_spi_pkg::byte_t     mem [bnn_spi_pkg::IMG_BYTES];
  bnn_spi_pkg::img_addr_t wr_ptr;
  bnn_spi_pkg::img_addr_t wr_ptr_next;

  // Clear only rewinds, every image overwrites all entries
  always_comb begin
    wr_ptr_next = wr_ptr;
    if (clear_buffer) wr_ptr_next = '0;
    else if (buffer_write_enable) wr_ptr_next = wr_ptr + 7'd1;
  end

  // Pointer and flags move together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      buffer_full  <= 1'b0;
      buffer_empty <= 1'b1;
    end else begin
      wr_ptr       <= wr_ptr_next;
      buffer_full  <= (wr_ptr_next == bnn_spi_pkg::FULL_PTR);
      buffer_empty <= (wr_ptr_next == '0);
    end
  end

  // Storage and synchronous read port
  always_ff @(posedge clk) begin
    if (buffer_write_enable && !clear_buffer) mem[wr_ptr] <= wr_data;
    rd_data <= mem[rd_addr];
  end

endmodule

//--- src/bnn_classifier.sv
`timescale 1ns/1ps

module bnn_classifier (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   bnn_start,
  input  bnn_spi_pkg::byte_t     rd_data,
  output bnn_spi_pkg::img_addr_t rd_addr,
  output logic                   result_ready,
  output bnn_spi_pkg::class_t    result_out
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_SCAN,
    C_FINISH,
    C_DONE
  } cls_state_t;

  cls_state_t             cls_state;
  logic                   start_prev;
  logic                   d_vld;
  logic                   d_last;
  bnn_spi_pkg::img_addr_t d_addr;
  bnn_spi_pkg::byte_t     d_mask;
  bnn_spi_pkg::score_t    scores [bnn_spi_pkg::NUM_CLASSES];
  bnn_spi_pkg::score_t    best_score;
  bnn_spi_pkg::class_t    best_class;

  // ========================================================================
  // Scan control and read pipeline
  // ========================================================================
  // Address k issued in one cycle, data k seen the next, summed after
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cls_state    <= C_IDLE;
      start_prev   <= 1'b0;
      rd_addr      <= '0;
      d_vld        <= 1'b0;
      d_last       <= 1'b0;
      result_ready <= 1'b0;
      result_out   <= '0;
    end else begin
      start_prev   <= bnn_start;
      d_vld        <= (cls_state == C_SCAN);
      d_last       <= (cls_state == C_SCAN) && (rd_addr == bnn_spi_pkg::LAST_ADDR);
      result_ready <= 1'b0;
      case (cls_state)
        C_IDLE: begin
          rd_addr <= '0;
          if (bnn_start && !start_prev) cls_state <= C_SCAN;
        end
        C_SCAN: begin
          rd_addr <= rd_addr + 7'd1;
          if (rd_addr == bnn_spi_pkg::LAST_ADDR) cls_state <= C_FINISH;
        end
        C_FINISH: begin
          // Wait for the last byte to drain from the pipe
          if (!d_vld) begin
            result_out   <= best_class;
            result_ready <= 1'b1;
            cls_state    <= C_DONE;
          end
        end
        default: begin
          if (!bnn_start) cls_state <= C_IDLE;
        end
      endcase
    end
  end

  // Address of the byte now on rd_data, for the weight lookup
  always_ff @(posedge clk) begin
    d_addr <= rd_addr;
  end

  // ========================================================================
  // XNOR popcount accumulate
  // ========================================================================
  // Only the low bits of the final byte belong to the image
  assign d_mask = d_last ? bnn_spi_pkg::LAST_BYTE_MASK : 8'hFF;

  always_ff @(posedge clk) begin
    for (int c = 0; c < bnn_spi_pkg::NUM_CLASSES; c++) begin
      if (cls_state == C_IDLE) begin
        scores[c] <= '0;
      end else if (d_vld) begin
        scores[c] <= scores[c] + bnn_spi_pkg::score_t'($countones(
          ~(rd_data ^ bnn_spi_pkg::weight_byte(bnn_spi_pkg::class_t'(c), d_addr)) & d_mask));
      end
    end
  end

  // Argmax, strict compare keeps the lowest index on a tie
  always_comb begin
    best_score = scores[0];
    best_class = '0;
    for (int c = 1; c < bnn_spi_pkg::NUM_CLASSES; c++) begin
      if (scores[c] > best_score) begin
        best_score = scores[c];
        best_class = bnn_spi_pkg::class_t'(c);
      end
    end
  end

endmodule

//--- src/bnn_spi_top.sv
`timescale 1ns/1ps

module bnn_spi_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     spi_sclk,
  input  logic                     spi_mosi,
  input  logic                     spi_cs_n,
  output bnn_spi_pkg::class_t      result_out,
  output logic                     result_ready,
  output logic                     status_ready,
  output logic                     send_image,
  output bnn_spi_pkg::ctrl_state_t fsm_state
);

  // Receiver to controller
  bnn_spi_pkg::byte_t     rx_data;
  logic                   byte_valid;
  logic                   byte_taken;
  logic                   cs_n_sync;

  // Controller to buffer and classifier
  logic                   buffer_write_enable;
  logic                   clear_buffer;
  logic                   buffer_full;
  logic                   buffer_empty;
  logic                   bnn_start;

  // Classifier read port
  bnn_spi_pkg::img_addr_t rd_addr;
  bnn_spi_pkg::byte_t     rd_data;

  // ========================================================================
  // SPI front end
  // ========================================================================
  spi_byte_rx spi_byte_rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_cs_n   (spi_cs_n),
    .byte_taken (byte_taken),
    .rx_data    (rx_data),
    .byte_valid (byte_valid),
    .cs_n_sync  (cs_n_sync)
  );

  // ========================================================================
  // Sequencer
  // ========================================================================
  ctrl_fsm ctrl_fsm_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cs_n_sync           (cs_n_sync),
    .rx_data             (rx_data),
    .byte_valid          (byte_valid),
    .buffer_full         (buffer_full),
    .buffer_empty        (buffer_empty),
    .result_ready        (result_ready),
    .byte_taken          (byte_taken),
    .buffer_write_enable (buffer_write_enable),
    .clear_buffer        (clear_buffer),
    .bnn_start           (bnn_start),
    .status_ready        (status_ready),
    .send_image          (send_image),
    .fsm_state           (fsm_state)
  );

  // ========================================================================
  // Image store and classifier
  // ========================================================================
  image_buffer image_buffer_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .buffer_write_enable (buffer_write_enable),
    .wr_data             (rx_data),
    .clear_buffer        (clear_buffer),
    .rd_addr             (rd_addr),
    .rd_data             (rd_data),
    .buffer_full         (buffer_full),
    .buffer_empty        (buffer_empty)
  );

  bnn_classifier bnn_classifier_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bnn_start    (bnn_start),
    .rd_data      (rd_data),
    .rd_addr      (rd_addr),
    .result_ready (result_ready),
    .result_out   (result_out)
  );

endmodule

//--- dv/bnn_spi_tests.svh
// How a frame ends after its bytes
typedef enum logic [1:0] {
  END_NORMAL,
  END_CS_ABORT,
  END_STALL
} end_mode_t;

// What the DUT should report for the frame
typedef enum logic [1:0] {
  EXP_NONE,
  EXP_STATUS,
  EXP_RESULT
} outcome_t;

// Name is 12 characters, space padded
typedef struct packed {
  logic [8*12-1:0]    name;
  bnn_spi_pkg::byte_t cmd;
  logic [7:0]         n_bytes;
  end_mode_t          end_mode;
  outcome_t           outcome;
} test_entry_t;

localparam int NUM_TESTS = 8;

// Image bytes themselves come from the random source in the testbench
localparam test_entry_t TESTS [NUM_TESTS] = '{
  '{"status_req  ", 8'hFE, 8'd0,   END_NORMAL,   EXP_STATUS},
  '{"image_first ", 8'hBF, 8'd113, END_NORMAL,   EXP_RESULT},
  '{"image_second", 8'hBF, 8'd113, END_NORMAL,   EXP_RESULT},
  '{"unknown_cmd ", 8'h5A, 8'd0,   END_NORMAL,   EXP_NONE},
  '{"image_abort ", 8'hBF, 8'd50,  END_CS_ABORT, EXP_NONE},
  '{"image_after ", 8'hBF, 8'd113, END_NORMAL,   EXP_RESULT},
  '{"image_stall ", 8'hBF, 8'd10,  END_STALL,    EXP_NONE},
  '{"image_final ", 8'hBF, 8'd113, END_NORMAL,   EXP_RESULT}
};

//--- dv/bnn_spi_checker.sv
`timescale 1ns/1ps

module bnn_spi_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     spi_sclk,
  input  logic                     spi_mosi,
  input  logic                     spi_cs_n,
  input  bnn_spi_pkg::class_t      result_out,
  input  logic                     result_ready,
  input  logic                     status_ready,
  input  logic                     send_image,
  input  bnn_spi_pkg::ctrl_state_t fsm_state,
  input  logic                     test_done,
  input  logic [7:0]               test_idx,
  output int                       pass_count,
  output int                       fail_count
);

  `include "bnn_spi_tests.svh"

  bnn_spi_pkg::byte_t       img_bytes [bnn_spi_pkg::IMG_BYTES];
  bnn_spi_pkg::byte_t       shift_reg;
  int                       bit_cnt;
  int                       byte_cnt;
  int                       pulse_cnt;
  int                       held_class;
  logic                     idle_cs_low;
  logic                     send_seen;
  logic                     prev_cs_n;
  bnn_spi_pkg::ctrl_state_t prev_state;

  // ========================================================================
  // Reference model
  // ========================================================================
  // Low byte of a*(2c+3) + 29c
  function automatic bnn_spi_pkg::byte_t class_weight(input int c, input int a);
    int w;
    w = a * (2 * c + 3) + 29 * c;
    return bnn_spi_pkg::byte_t'(w & 255);
  endfunction

  // Highest XNOR match count, lowest class wins a tie
  function automatic int expected_class();
    int best;
    int best_score;
    int score;
    bnn_spi_pkg::byte_t mask;
    best       = 0;
    best_score = -1;
    for (int c = 0; c < bnn_spi_pkg::NUM_CLASSES; c++) begin
      score = 0;
      for (int a = 0; a < bnn_spi_pkg::IMG_BYTES; a++) begin
        mask = 8'hFF;
        if (a == bnn_spi_pkg::IMG_BYTES - 1) begin
          mask = bnn_spi_pkg::byte_t'((1 << bnn_spi_pkg::LAST_BYTE_BITS) - 1);
        end
        score += $countones(~(img_bytes[a] ^ class_weight(c, a)) & mask);
      end
      if (score > best_score) begin
        best_score = score;
        best       = c;
      end
    end
    return best;
  endfunction

  // ========================================================================
  // SPI pin decoder
  // ========================================================================
  // sclk is low at a chip select fall in mode 0
  always @(posedge spi_sclk or negedge spi_cs_n) begin
    if (!spi_sclk) begin
      bit_cnt  = 0;
      byte_cnt = 0;
    end else if (!spi_cs_n) begin
      shift_reg = {shift_reg[6:0], spi_mosi};
      bit_cnt   = bit_cnt + 1;
      if (bit_cnt == 8) begin
        // Byte 0 is the command, image starts at byte 1
        if (byte_cnt >= 1 && byte_cnt <= bnn_spi_pkg::IMG_BYTES) begin
          img_bytes[byte_cnt - 1] = shift_reg;
        end
        byte_cnt = byte_cnt + 1;
        bit_cnt  = 0;
      end
    end
  end

  // ========================================================================
  // Per-test comparison
  // ========================================================================
  task automatic check_test(input int idx);
    test_entry_t t;
    int   exp_class;
    int   exp_pulses;
    logic exp_status;
    logic exp_idle;
    logic exp_send;
    logic ok;
    if (idx >= NUM_TESTS) begin
      $display("Test index %0d reported by the testbench is outside the table", idx);
      fail_count++;
    end else begin
      t          = TESTS[idx];
      exp_pulses = (t.outcome == EXP_RESULT) ? 1 : 0;
      exp_status = (t.outcome == EXP_STATUS);
      exp_idle   = (t.end_mode == END_STALL);
      exp_send   = (t.cmd == bnn_spi_pkg::IMG_TX_REQUEST_CODE);
      // Class stays from the last result when none is due
      if (t.outcome == EXP_RESULT) held_class = expected_class();
      exp_class  = held_class;
      ok = (int'(result_out) == exp_class) && (status_ready == exp_status) &&
           (pulse_cnt == exp_pulses) && (idle_cs_low == exp_idle) &&
           (send_seen == exp_send) && (send_image == 1'b0) &&
           (fsm_state == bnn_spi_pkg::S_IDLE) && (byte_cnt == int'(t.n_bytes) + 1);
      if (ok) begin
        $display("[PASS] %s class=%0d status=%0d pulses=%0d",
                 t.name, result_out, status_ready, pulse_cnt);
        pass_count++;
      end else begin
        $write("[FAIL] %s expected class=%0d status=%0d pulses=%0d idle_cs_low=%0d",
               t.name, exp_class, exp_status, exp_pulses, exp_idle);
        $write(" send_seen=%0d send=0 state=%0d bytes=%0d,",
               exp_send, int'(bnn_spi_pkg::S_IDLE), int'(t.n_bytes) + 1);
        $write(" actual class=%0d status=%0d pulses=%0d idle_cs_low=%0d",
               result_out, status_ready, pulse_cnt, idle_cs_low);
        $display(" send_seen=%0d send=%0d state=%0d bytes=%0d",
                 send_seen, send_image, fsm_state, byte_cnt);
        fail_count++;
      end
    end
  endtask

  // Counts result pulses and idle entries between test boundaries
  always @(posedge clk) begin
    if (!rst_n) begin
      pulse_cnt   = 0;
      held_class  = 0;
      idle_cs_low = 1'b0;
      send_seen   = 1'b0;
      pass_count  = 0;
      fail_count  = 0;
      prev_state  = bnn_spi_pkg::S_IDLE;
      prev_cs_n   = 1'b1;
    end else begin
      if (result_ready) pulse_cnt = pulse_cnt + 1;
      if (send_image) send_seen = 1'b1;
      // Clear finished while the host still held the frame open
      if (fsm_state == bnn_spi_pkg::S_IDLE && prev_state == bnn_spi_pkg::S_CLEAR &&
          !prev_cs_n) begin
        idle_cs_low = 1'b1;
      end
      prev_state = fsm_state;
      // Pin level at the edge that moved the FSM
      prev_cs_n  = spi_cs_n;
      if (test_done) begin
        check_test(int'(test_idx));
        pulse_cnt   = 0;
        idle_cs_low = 1'b0;
        send_seen   = 1'b0;
      end
    end
  end

endmodule

//--- dv/tb_bnn_spi_top.sv
`timescale 1ns/1ps

module tb_bnn_spi_top;

  `include "bnn_spi_tests.svh"

  localparam int CLK_PERIOD  = 4;
  // clk cycles per sclk half period
  localparam int HALF_SCLK   = 4;
  localparam int DRIVE_DELAY = 1;

  logic                     clk;
  logic                     rst_n;
  logic                     spi_sclk;
  logic                     spi_mosi;
  logic                     spi_cs_n;
  bnn_spi_pkg::class_t      result_out;
  logic                     result_ready;
  logic                     status_ready;
  logic                     send_image;
  bnn_spi_pkg::ctrl_state_t fsm_state;
  logic                     test_done;
  logic [7:0]               test_idx;
  int                       pass_count;
  int                       fail_count;
  logic [31:0]              rng_state;

  bnn_spi_top bnn_spi_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_sclk     (spi_sclk),
    .spi_mosi     (spi_mosi),
    .spi_cs_n     (spi_cs_n),
    .result_out   (result_out),
    .result_ready (result_ready),
    .status_ready (status_ready),
    .send_image   (send_image),
    .fsm_state    (fsm_state)
  );

  bnn_spi_checker bnn_spi_checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_sclk     (spi_sclk),
    .spi_mosi     (spi_mosi),
    .spi_cs_n     (spi_cs_n),
    .result_out   (result_out),
    .result_ready (result_ready),
    .status_ready (status_ready),
    .send_image   (send_image),
    .fsm_state    (fsm_state),
    .test_done    (test_done),
    .test_idx     (test_idx),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ========================================================================
  // SPI host helpers
  // ========================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Leaves the caller just past a rising clk edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Mode 0, MSB first, data set up while sclk is low
  task automatic send_byte(input bnn_spi_pkg::byte_t value);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = value[i];
      wait_cycles(HALF_SCLK);
      spi_sclk = 1'b1;
      wait_cycles(HALF_SCLK);
      spi_sclk = 1'b0;
    end
  endtask

  task automatic wait_idle();
    while (fsm_state != bnn_spi_pkg::S_IDLE) wait_cycles(1);
  endtask

  task automatic run_test(input int idx);
    test_entry_t t;
    t = TESTS[idx];
    spi_cs_n = 1'b0;
    wait_cycles(HALF_SCLK);
    send_byte(t.cmd);
    // Full random bytes, so the unused top bits of the last byte vary too
    for (int b = 0; b < int'(t.n_bytes); b++) begin
      rng_state = xorshift32(rng_state);
      send_byte(rng_state[7:0]);
    end
    wait_cycles(HALF_SCLK);
    // Frame stays open with sclk idle until the controller gives up
    if (t.end_mode == END_STALL) wait_idle();
    spi_cs_n = 1'b1;
    wait_cycles(HALF_SCLK);
    wait_idle();
    wait_cycles(2);
    test_idx  = 8'(idx);
    test_done = 1'b1;
    wait_cycles(1);
    test_done = 1'b0;
    // Chip select gap before the next frame
    wait_cycles(2 * HALF_SCLK);
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================
  initial begin
    rst_n     = 1'b0;
    spi_sclk  = 1'b0;
    spi_mosi  = 1'b0;
    spi_cs_n  = 1'b1;
    test_done = 1'b0;
    test_idx  = 8'd0;
    rng_state = 32'hbc2c07c9;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    wait_cycles(4);
    for (int i = 0; i < NUM_TESTS; i++) run_test(i);
    wait_cycles(4);
    $display("Tests: %0d run, %0d passed, %0d failed", NUM_TESTS, pass_count, fail_count);
    if (fail_count == 0 && pass_count == NUM_TESTS) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // ========================================================================
  // Watchdog
  // ========================================================================
  // 64 cycles per byte, stall tests add one timeout, then doubled
  initial begin
    int limit;
    limit = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit += (int'(TESTS[i].n_bytes) + 1) * 64;
      if (TESTS[i].end_mode == END_STALL) limit += bnn_spi_pkg::TIMEOUT_CYCLES;
    end
    limit = limit * 2 + 2000;
    repeat (limit) @(posedge clk);
    $display("Run timed out after %0d clock cycles without finishing all tests", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- bnn_spi_top.f
+incdir+dv
src/bnn_spi_pkg.sv
src/spi_byte_rx.sv
src/ctrl_fsm.sv
src/image_buffer.sv
src/bnn_classifier.sv
src/bnn_spi_top.sv
dv/bnn_spi_checker.sv
dv/tb_bnn_spi_top.sv

//--- Makefile
# Verilator build and run for the SPI BNN classifier testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_bnn_spi_top
FILELIST  ?= bnn_spi_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_LINE ?= STATUS: PASS

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) dv/bnn_spi_tests.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal and the pass line decides the exit status
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_LINE)'

clean:
	rm -rf $(OBJ_DIR)
